//--- common/elevator_config.svh
`ifndef ELEVATOR_CONFIG_SVH
`define ELEVATOR_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Building geometry
//////////////////////////////////////////////////////////////////////

// Floors are numbered 0 to NUM_FLOORS-1
`define NUM_FLOORS      11

// Wide enough for any floor index
`define FLOOR_WIDTH     4

//////////////////////////////////////////////////////////////////////
// Movement state machine interface
//////////////////////////////////////////////////////////////////////

// Width of the state code driven by the movement FSM
`define STATE_WIDTH     6

// Codes 0 up to this value mean "stopped at floor <code>"
`define LAST_STOP_STATE 10

//////////////////////////////////////////////////////////////////////
// Request stack
//////////////////////////////////////////////////////////////////////

// One slot per floor, pointer must reach STACK_DEPTH itself
`define STACK_DEPTH     11
`define PTR_WIDTH       4

`endif

//--- common/elevator_pkg.sv
`include "elevator_config.svh"

package elevator_pkg;

    //////////////////////////////////////////////////////////////////////
    // Floors and buttons
    //////////////////////////////////////////////////////////////////////

    // Floor index, 0 is the lowest floor
    typedef logic [`FLOOR_WIDTH-1:0] floor_t;

    // One bit per floor, bit i belongs to floor i
    // Used for call buttons, panel buttons and their lights
    typedef logic [`NUM_FLOORS-1:0] floor_mask_t;

    //////////////////////////////////////////////////////////////////////
    // Movement FSM side
    //////////////////////////////////////////////////////////////////////

    // State code of the external movement FSM
    // 0..LAST_STOP_STATE are stop states, higher codes are travel or fault
    typedef logic [`STATE_WIDTH-1:0] elevator_state_t;

    // Command to the movement FSM
    typedef struct packed {
        // Target floor, or the current floor when idle
        floor_t floor_selector;
        // 1 means up
        logic   direction;
        // Start a move toward floor_selector
        logic   activate;
    } move_cmd_t;

endpackage

//--- common/request_pkg.sv
`include "elevator_config.svh"

package request_pkg;

    // A floor request, used for stack pushes and for the stack top
    typedef struct packed {
        logic                 valid;
        elevator_pkg::floor_t floor;
    } request_t;

    // Number of entries held, 0 means empty
    typedef logic [`PTR_WIDTH-1:0] stack_ptr_t;

    // Notice that the elevator is stopped at a requested floor
    // Capture clears both lights of that floor on it
    typedef struct packed {
        logic                 valid;
        elevator_pkg::floor_t floor;
    } served_t;

endpackage

//--- request_capture/request_capture.sv
`include "elevator_config.svh"

module request_capture (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t floor_call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  elevator_pkg::floor_t      current_floor,
    input  logic                      emergency_btn,
    input  logic                      power_switch,
    input  logic                      full,
    input  request_pkg::served_t      served,
    output request_pkg::request_t     push,
    output logic                      flush,
    output logic                      service_enable,
    output elevator_pkg::floor_mask_t call_button_lights,
    output elevator_pkg::floor_mask_t panel_button_lights
);

    elevator_pkg::floor_mask_t panel_qual;
    elevator_pkg::floor_mask_t call_qual;
    elevator_pkg::floor_mask_t panel_set;
    elevator_pkg::floor_mask_t call_set;
    elevator_pkg::floor_mask_t served_mask;
    elevator_pkg::floor_t      panel_pick;
    elevator_pkg::floor_t      call_pick;
    elevator_pkg::floor_t      pick_floor;
    logic                      panel_hit;
    logic                      call_hit;
    logic                      take;

    // Lowest set bit of a floor mask, 0 when the mask is empty
    function automatic elevator_pkg::floor_t lowest_floor(
        input elevator_pkg::floor_mask_t mask
    );
        elevator_pkg::floor_t pick;
        pick = '0;
        for (int i = `NUM_FLOORS - 1; i >= 0; i--) begin
            if (mask[i]) begin
                pick = elevator_pkg::floor_t'(i);
            end
        end
        return pick;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Service control
    //////////////////////////////////////////////////////////////////////

    assign flush          = !power_switch || emergency_btn;
    assign service_enable = !flush;

    //////////////////////////////////////////////////////////////////////
    // Button qualification and arbitration
    //////////////////////////////////////////////////////////////////////

    // A press counts only for another floor whose light is still off
    always_comb begin
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            panel_qual[i] = panel_buttons[i] && !panel_button_lights[i] &&
                            (current_floor != elevator_pkg::floor_t'(i));
            call_qual[i]  = floor_call_buttons[i] && !call_button_lights[i] &&
                            (current_floor != elevator_pkg::floor_t'(i));
        end
    end

    assign panel_hit  = |panel_qual;
    assign call_hit   = |call_qual;
    assign panel_pick = lowest_floor(panel_qual);
    assign call_pick  = lowest_floor(call_qual);

    // Panel beats call, losers wait for a later cycle while still held
    assign take       = (panel_hit || call_hit) && !flush;
    assign pick_floor = panel_hit ? panel_pick : call_pick;

    assign panel_set = (take && panel_hit) ?
                       (elevator_pkg::floor_mask_t'(1'b1) << panel_pick) : '0;
    assign call_set  = (take && !panel_hit) ?
                       (elevator_pkg::floor_mask_t'(1'b1) << call_pick) : '0;

    // Light still goes on when the stack is full, only the push is lost
    assign push.valid = take && !full;
    assign push.floor = pick_floor;

    assign served_mask = served.valid ?
                         (elevator_pkg::floor_mask_t'(1'b1) << served.floor) : '0;

    //////////////////////////////////////////////////////////////////////
    // Button lights
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else if (flush) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else begin
            // Served floor is the current one, so it never collides with a set
            call_button_lights  <= (call_button_lights | call_set) & ~served_mask;
            panel_button_lights <= (panel_button_lights | panel_set) & ~served_mask;
        end
    end

endmodule

//--- request_stack/request_stack.sv
`include "elevator_config.svh"

module request_stack (
    input  logic                  clock,
    input  logic                  reset_n,
    input  request_pkg::request_t push,
    input  logic                  pop,
    input  logic                  flush,
    output request_pkg::request_t top,
    output logic                  full
);

    // Slot 0 is the oldest entry, slot ptr-1 the newest
    elevator_pkg::floor_t   slots [`STACK_DEPTH];
    request_pkg::stack_ptr_t ptr;
    request_pkg::stack_ptr_t top_idx;
    request_pkg::stack_ptr_t wr_idx;
    logic                   empty;
    logic                   do_pop;
    logic                   do_replace;
    logic                   do_push;
    logic                   wr_en;

    assign empty   = (ptr == '0);
    assign full    = (ptr == request_pkg::stack_ptr_t'(`STACK_DEPTH));
    assign top_idx = ptr - 1'b1;

    //////////////////////////////////////////////////////////////////////
    // Operation decode
    //////////////////////////////////////////////////////////////////////

    // Flush overrides both push and pop
    assign do_pop     = pop && !empty && !flush;

    // Pop and push together overwrite the top slot in place
    assign do_replace = do_pop && push.valid;
    assign do_push    = push.valid && !full && !flush && !do_pop;

    assign wr_en  = do_push || do_replace;
    assign wr_idx = do_replace ? top_idx : ptr;

    //////////////////////////////////////////////////////////////////////
    // Pointer and storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ptr <= '0;
        end else if (flush) begin
            ptr <= '0;
        end else if (do_pop && !do_replace) begin
            ptr <= ptr - 1'b1;
        end else if (do_push) begin
            ptr <= ptr + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            slots[wr_idx] <= push.floor;
        end
    end

    // Top is read without removal, the dispatcher decides when to pop
    always_comb begin
        top.valid = !empty;
        top.floor = empty ? '0 : slots[top_idx];
    end

endmodule

//--- verilog/floor_dispatch.sv
`include "elevator_config.svh"

module floor_dispatch (
    input  request_pkg::request_t         top,
    input  logic                          service_enable,
    input  elevator_pkg::floor_t          current_floor,
    input  elevator_pkg::elevator_state_t elevator_state,
    output elevator_pkg::move_cmd_t       move_cmd,
    output logic                          pop,
    output request_pkg::served_t          served
);

    logic stop_state;
    logic pending;
    logic serve_ok;
    logic at_target;

    //////////////////////////////////////////////////////////////////////
    // Request decode
    //////////////////////////////////////////////////////////////////////

    // Stop codes run from 0 to LAST_STOP_STATE, one per floor
    assign stop_state = (elevator_state <=
                         elevator_pkg::elevator_state_t'(`LAST_STOP_STATE));

    assign pending   = service_enable && top.valid;
    assign serve_ok  = pending && stop_state;
    assign at_target = (top.floor == current_floor);

    //////////////////////////////////////////////////////////////////////
    // Movement command
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        move_cmd.floor_selector = pending ? top.floor : current_floor;
        move_cmd.activate       = serve_ok && !at_target;
        // Natural direction, only meaningful while activate is high
        move_cmd.direction      = move_cmd.activate && (top.floor > current_floor);
    end

    //////////////////////////////////////////////////////////////////////
    // Serving
    //////////////////////////////////////////////////////////////////////

    // Stopped at the requested floor, so drop the entry and its lights
    assign pop = serve_ok && at_target;

    always_comb begin
        served.valid = pop;
        served.floor = top.floor;
    end

endmodule

//--- verilog/floor_logic_top.sv
module floor_logic_top (
    input  logic                          clock,
    input  logic                          reset_n,
    input  elevator_pkg::floor_mask_t     floor_call_buttons,
    input  elevator_pkg::floor_mask_t     panel_buttons,
    input  logic                          emergency_btn,
    input  logic                          power_switch,
    input  elevator_pkg::floor_t          current_floor,
    input  elevator_pkg::elevator_state_t elevator_state,
    output elevator_pkg::floor_mask_t     call_button_lights,
    output elevator_pkg::floor_mask_t     panel_button_lights,
    output elevator_pkg::move_cmd_t       move_cmd
);

    request_pkg::request_t push;
    request_pkg::request_t top;
    request_pkg::served_t  served;
    logic                  flush;
    logic                  service_enable;
    logic                  full;
    logic                  pop;

    // Buttons in, lights and push requests out
    request_capture u_request_capture (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .current_floor       (current_floor),
        .emergency_btn       (emergency_btn),
        .power_switch        (power_switch),
        .full                (full),
        .served              (served),
        .push                (push),
        .flush               (flush),
        .service_enable      (service_enable),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    request_stack u_request_stack (
        .clock   (clock),
        .reset_n (reset_n),
        .push    (push),
        .pop     (pop),
        .flush   (flush),
        .top     (top),
        .full    (full)
    );

    // Newest request drives the movement FSM
    floor_dispatch u_floor_dispatch (
        .top            (top),
        .service_enable (service_enable),
        .current_floor  (current_floor),
        .elevator_state (elevator_state),
        .move_cmd       (move_cmd),
        .pop            (pop),
        .served         (served)
    );

endmodule

//--- tests/floor_logic_assertions.sv
`include "elevator_config.svh"

module floor_logic_assertions (
    input logic                          clock,
    input logic                          reset_n,
    input elevator_pkg::floor_mask_t     floor_call_buttons,
    input elevator_pkg::floor_mask_t     panel_buttons,
    input logic                          emergency_btn,
    input logic                          power_switch,
    input elevator_pkg::floor_t          current_floor,
    input elevator_pkg::elevator_state_t elevator_state,
    input elevator_pkg::floor_mask_t     call_button_lights,
    input elevator_pkg::floor_mask_t     panel_button_lights,
    input elevator_pkg::move_cmd_t       move_cmd,
    input request_pkg::request_t         top
);

    int unsigned               fail_count = 0;
    logic                      off_service;
    logic                      ready;
    elevator_pkg::floor_mask_t here_mask;
    elevator_pkg::floor_mask_t lights;
    elevator_pkg::floor_mask_t panel_new;
    elevator_pkg::floor_mask_t call_new;

    task automatic count_failure(input string what);
        fail_count++;
        $error("%s", what);
    endtask

    assign off_service = emergency_btn || !power_switch;
    // Running, a request is stacked and the car is in a stop state
    assign ready       = !off_service && top.valid &&
                         (elevator_state <= elevator_pkg::elevator_state_t'(`LAST_STOP_STATE));
    assign here_mask   = elevator_pkg::floor_mask_t'(1'b1) << current_floor;
    assign lights      = call_button_lights | panel_button_lights;
    // Presses allowed to light a button this cycle
    assign panel_new   = panel_buttons & ~panel_button_lights & ~here_mask;
    assign call_new    = floor_call_buttons & ~call_button_lights & ~here_mask;

    //////////////////////////////////////////////////////////////////////
    // Capture and lights
    //////////////////////////////////////////////////////////////////////

    a_reset_idle: assert property (@(posedge clock)
        $rose(reset_n) |-> lights == '0 && !move_cmd.activate)
        else count_failure("lights or activate set right after reset");

    for (genvar i = 0; i < `NUM_FLOORS; i++) begin : g_floor
        localparam elevator_pkg::floor_mask_t lower_floors =
            elevator_pkg::floor_mask_t'((1 << i) - 1);

        // Lowest panel press wins, call presses only when no panel press qualifies
        a_panel_pick: assert property (@(posedge clock) disable iff (!reset_n)
            !off_service && panel_new[i] && (panel_new & lower_floors) == '0
            |=> panel_button_lights[i])
            else count_failure("winning panel press did not light its button");
        a_call_pick: assert property (@(posedge clock) disable iff (!reset_n)
            !off_service && panel_new == '0 && call_new[i] &&
            (call_new & lower_floors) == '0 |=> call_button_lights[i])
            else count_failure("winning call press did not light its button");
    end

    a_call_waits: assert property (@(posedge clock) disable iff (!reset_n)
        !off_service && panel_new != '0
        |=> (call_button_lights & ~$past(call_button_lights)) == '0)
        else count_failure("call light set in a cycle taken by a panel press");
    a_here_dark: assert property (@(posedge clock) disable iff (!reset_n)
        (lights & here_mask) == '0 |=> (lights & $past(here_mask)) == '0)
        else count_failure("press at the current floor lit a button");
    a_served_clear: assert property (@(posedge clock) disable iff (!reset_n)
        ready && top.floor == current_floor |=> (lights & $past(here_mask)) == '0)
        else count_failure("served floor still has a light on");
    a_flush_clear: assert property (@(posedge clock) disable iff (!reset_n)
        off_service |=> lights == '0)
        else count_failure("lights still on after flush");

    //////////////////////////////////////////////////////////////////////
    // Dispatch
    //////////////////////////////////////////////////////////////////////

    a_dispatch: assert property (@(posedge clock) disable iff (!reset_n)
        ready && top.floor != current_floor |-> move_cmd.activate &&
        move_cmd.floor_selector == top.floor &&
        move_cmd.direction == (top.floor > current_floor))
        else count_failure("wrong activate, selector or direction for the top request");
    a_moving_idle: assert property (@(posedge clock) disable iff (!reset_n)
        elevator_state > elevator_pkg::elevator_state_t'(`LAST_STOP_STATE)
        |-> !move_cmd.activate)
        else count_failure("activate raised outside a stop state");
    a_idle_selector: assert property (@(posedge clock) disable iff (!reset_n)
        off_service || !top.valid
        |-> !move_cmd.activate && move_cmd.floor_selector == current_floor)
        else count_failure("idle controller does not show the current floor");

endmodule

bind floor_logic_top floor_logic_assertions u_assertions (
    .clock               (clock),
    .reset_n             (reset_n),
    .floor_call_buttons  (floor_call_buttons),
    .panel_buttons       (panel_buttons),
    .emergency_btn       (emergency_btn),
    .power_switch        (power_switch),
    .current_floor       (current_floor),
    .elevator_state      (elevator_state),
    .call_button_lights  (call_button_lights),
    .panel_button_lights (panel_button_lights),
    .move_cmd            (move_cmd),
    .top                 (top)
);

//--- tests/floor_logic_tb.sv
`include "elevator_config.svh"

module floor_logic_tb;

    localparam int clock_period    = 100;
    // Reset plus six tests of at most 60 cycles each
    localparam int watchdog_cycles = 4 + 6 * 60;

    logic                          clock;
    logic                          reset_n;
    elevator_pkg::floor_mask_t     floor_call_buttons;
    elevator_pkg::floor_mask_t     panel_buttons;
    logic                          emergency_btn;
    logic                          power_switch;
    elevator_pkg::floor_t          current_floor;
    elevator_pkg::elevator_state_t elevator_state;
    elevator_pkg::floor_mask_t     call_button_lights;
    elevator_pkg::floor_mask_t     panel_button_lights;
    elevator_pkg::move_cmd_t       move_cmd;

    // Expected stack, newest entry at the back
    elevator_pkg::floor_t model_stack[$];
    logic [31:0]          lfsr_state;
    int unsigned          errors;
    int unsigned          tests_done;
    int unsigned          fails_seen;

    floor_logic_top dut (.*);

    initial begin
        clock = 1'b0;
        forever begin
            #(clock_period / 2);
            clock = ~clock;
        end
    end

    initial begin
        #(clock_period * watchdog_cycles);
        $display("Watchdog expired, tests did not finish within %0d cycles", watchdog_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic random_bits(input int width, output int unsigned value);
        value = 0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic elevator_pkg::floor_mask_t floor_bit(input elevator_pkg::floor_t floor);
        return elevator_pkg::floor_mask_t'(1'b1) << floor;
    endfunction

    // Random floor outside the excluded set
    task automatic pick_floor(input elevator_pkg::floor_mask_t excluded,
                              output elevator_pkg::floor_t floor);
        int unsigned bits;
        random_bits(8, bits);
        floor = elevator_pkg::floor_t'(bits % `NUM_FLOORS);
        while (excluded[floor]) begin
            random_bits(8, bits);
            floor = elevator_pkg::floor_t'(bits % `NUM_FLOORS);
        end
    endtask

    task automatic press(input logic use_panel, input elevator_pkg::floor_t floor);
        if (use_panel) begin
            panel_buttons[floor] = 1'b1;
        end else begin
            floor_call_buttons[floor] = 1'b1;
        end
        @(negedge clock);
        panel_buttons      = '0;
        floor_call_buttons = '0;
    endtask

    task automatic clear_requests();
        emergency_btn = 1'b1;
        @(negedge clock);
        emergency_btn = 1'b0;
    endtask

    task automatic check_selector();
        elevator_pkg::floor_t expected;
        if (model_stack.size() == 0) begin
            expected = current_floor;
        end else begin
            expected = model_stack[$];
        end
        if (move_cmd.floor_selector !== expected) begin
            errors++;
            $display("[FAIL] time %0t: move_cmd.floor_selector is %0d, expected %0d",
                     $time, move_cmd.floor_selector, expected);
        end
    endtask

    // A push is lost once the stack holds STACK_DEPTH entries
    task automatic press_tracked(input logic use_panel, input elevator_pkg::floor_t floor);
        press(use_panel, floor);
        if (model_stack.size() < `STACK_DEPTH) begin
            model_stack.push_back(floor);
        end
        check_selector();
    endtask

    // Stop at the floor on top so it gets popped
    task automatic serve_top(input elevator_pkg::floor_t floor);
        current_floor  = floor;
        elevator_state = elevator_pkg::elevator_state_t'(floor);
        @(negedge clock);
        void'(model_stack.pop_back());
        check_selector();
    endtask

    function automatic int unsigned total_failures();
        return errors + dut.u_assertions.fail_count;
    endfunction

    task automatic finish_test(input string name);
        tests_done++;
        if (total_failures() == fails_seen) begin
            $display("Test %0d %s: ok", tests_done, name);
        end else begin
            $display("Test %0d %s: %0d new errors", tests_done, name,
                     total_failures() - fails_seen);
        end
        fails_seen = total_failures();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    initial begin
        elevator_pkg::floor_t here;
        elevator_pkg::floor_t fa;
        elevator_pkg::floor_t fb;
        elevator_pkg::floor_t fc;
        int unsigned          bits;

        lfsr_state         = 32'ha2537e07;
        errors             = 0;
        tests_done         = 0;
        fails_seen         = 0;
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        current_floor      = '0;
        elevator_state     = '0;
        repeat (4) @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);
        finish_test("reset state");

        pick_floor('0, here);
        pick_floor(floor_bit(here), fa);
        current_floor  = here;
        elevator_state = elevator_pkg::elevator_state_t'(here);
        press(1'b1, fa);
        repeat (2) @(negedge clock);
        clear_requests();
        finish_test("panel press");

        pick_floor('0, here);
        current_floor  = here;
        elevator_state = elevator_pkg::elevator_state_t'(here);
        press(1'b1, here);
        pick_floor(floor_bit(here), fa);
        pick_floor(floor_bit(here) | floor_bit(fa), fb);
        panel_buttons[fa]      = 1'b1;
        floor_call_buttons[fb] = 1'b1;
        repeat (2) @(negedge clock);
        panel_buttons      = '0;
        floor_call_buttons = '0;
        @(negedge clock);
        clear_requests();
        finish_test("ignored presses");

        // Collect three requests while travelling, then serve from the top
        model_stack.delete();
        pick_floor('0, here);
        current_floor  = here;
        elevator_state = 6'd40;
        pick_floor(floor_bit(here), fa);
        pick_floor(floor_bit(here) | floor_bit(fa), fb);
        pick_floor(floor_bit(here) | floor_bit(fa) | floor_bit(fb), fc);
        press_tracked(1'b1, fa);
        press_tracked(1'b1, fb);
        press_tracked(1'b1, fc);
        serve_top(fc);
        serve_top(fb);
        clear_requests();
        model_stack.delete();
        current_floor  = '0;
        elevator_state = 6'd40;
        for (int f = 1; f < `NUM_FLOORS; f++) begin
            press_tracked(1'b1, elevator_pkg::floor_t'(f));
        end
        // Call lights are separate, so these count as new requests
        press_tracked(1'b0, elevator_pkg::floor_t'(1));
        press_tracked(1'b0, elevator_pkg::floor_t'(2));
        clear_requests();
        finish_test("lifo order");

        pick_floor('0, here);
        random_bits(5, bits);
        current_floor  = here;
        elevator_state = elevator_pkg::elevator_state_t'(`LAST_STOP_STATE + 1 + bits);
        pick_floor(floor_bit(here), fa);
        press(1'b1, fa);
        pick_floor(floor_bit(here) | floor_bit(fa), fb);
        press(1'b0, fb);
        repeat (3) @(negedge clock);
        clear_requests();
        finish_test("moving state");

        pick_floor('0, here);
        current_floor  = here;
        elevator_state = elevator_pkg::elevator_state_t'(here);
        pick_floor(floor_bit(here), fa);
        press(1'b1, fa);
        pick_floor(floor_bit(here) | floor_bit(fa), fb);
        press(1'b0, fb);
        clear_requests();
        repeat (2) @(negedge clock);
        press(1'b1, fa);
        power_switch = 1'b0;
        repeat (2) @(negedge clock);
        power_switch = 1'b1;
        repeat (2) @(negedge clock);
        finish_test("flush");

        $display("%0d tests run, %0d failed checks", tests_done, total_failures());
        if (total_failures() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+common
common/elevator_pkg.sv
common/request_pkg.sv
request_capture/request_capture.sv
request_stack/request_stack.sv
verilog/floor_dispatch.sv
verilog/floor_logic_top.sv
tests/floor_logic_assertions.sv
tests/floor_logic_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the floor logic testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
fail_message="FAIL: see errors above"

verilator --binary --timing --assert \
    -f sim.f \
    --top-module floor_logic_tb \
    -Mdir "$build_dir"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench reaches its summary
"$build_dir/Vfloor_logic_tb" +verilator+error+limit+1000 > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -qF "$fail_message" "$log_file"; then
    echo "Simulation reported failures, see $log_file"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi
echo "Simulation finished without failures"
exit 0
